// File: include/pkt_check_config.svh
// packet sanity checker configuration for lane count, lane width, destinations and counters
`ifndef PKT_CHECK_CONFIG_SVH
`define PKT_CHECK_CONFIG_SVH

// number of 64-bit lanes carried in one beat
// the checker is built for anything from 1 to 4 lanes
`define PKT_WORDS 2

// width of one lane in bits
// the terminator word and the start word layout both depend on 64
`define PKT_WIDTH 64

// number of entries in the destination address table
`define PKT_NUM_DEST 4

// width of each error counter, counters wrap at this width
`define PKT_CNT_WIDTH 32

`endif

// File: logic/pkt_check_pkg.sv
// packet sanity checker types, destination address table and terminator constant
`default_nettype none

`include "pkt_check_config.svh"

package pkt_check_pkg;

	// one lane of bus data
	typedef logic [`PKT_WIDTH-1:0] lane_word_t;

	// all lanes of one beat, lane 0 in the low bits
	typedef lane_word_t [`PKT_WORDS-1:0] beat_data_t;

	// one bit per lane, used for sop, eop, pad and every error flag
	typedef logic [`PKT_WORDS-1:0] lane_flags_t;

	// a start word holds the destination in 63:16 and the serial in 15:0
	typedef logic [47:0] mac_addr_t;
	typedef logic [15:0] serial_t;

	// expected serial per destination, entry k belongs to dest_table[k]
	typedef serial_t [`PKT_NUM_DEST-1:0] serial_table_t;

	typedef logic [`PKT_CNT_WIDTH-1:0] err_count_t;

	// known destinations, all distinct and none of them zero
	localparam mac_addr_t dest_table [`PKT_NUM_DEST] = '{
		48'h0200_0000_1a01,
		48'h0200_0000_2b02,
		48'h0600_1234_3c03,
		48'h0a00_5678_4d04
	};

	// the terminator bytes in transmit order, first byte ends up in the top of the word
	// the list holds exactly eight bytes and is sized from the lane width,
	// so any lane width other than 64 refuses to elaborate
	localparam logic [7:0] term_bytes [`PKT_WIDTH/8] = '{
		"c", "a", "b", "o", "o", "s", "e", "."
	};

	// every unpadded packet must end with this word
	localparam lane_word_t term_word = {
		term_bytes[0],
		term_bytes[1],
		term_bytes[2],
		term_bytes[3],
		term_bytes[4],
		term_bytes[5],
		term_bytes[6],
		term_bytes[7]
	};

endpackage

`default_nettype wire

// File: logic/term_check.sv
// terminator checker that flags unpadded end-of-packet words which are not "caboose."
`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_config.svh"

module term_check import pkt_check_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         lane_flags_t beat_eop,
	input  wire         lane_flags_t beat_pad,
	input  wire         beat_data_t  beat_data,
	output lane_flags_t bad_term
);

	// per-lane result of the word compare, before the packet flags are applied
	lane_flags_t term_miss;

	// lanes whose word has to be checked in this beat
	lane_flags_t term_required;

	for (genvar i = 0; i < `PKT_WORDS; i++) begin : g_lane
		// full 64-bit compare, any differing byte counts as a bad terminator
		assign term_miss[i] = (beat_data[i] != term_word);
	end

	// a padded packet ends in a short final word, so only unpadded ends are checked
	assign term_required = beat_eop & ~beat_pad;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bad_term <= '0;
		end else begin
			bad_term <= term_required & term_miss;
		end
	end

	// the pad flag only qualifies the last word of a packet.
	// a lane with pad but no eop means the source marked the wrong word
	pad_needs_eop: assert property (
		@(posedge clk) disable iff (!rst_n)
		(beat_pad & ~beat_eop) == '0
	)
	else $error("pad set on a lane without eop, pad=%b eop=%b", beat_pad, beat_eop);

endmodule

`default_nettype wire

// File: logic/dest_serial_check.sv
// destination and serial checker that looks up start words and tracks a serial per destination
`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_config.svh"

module dest_serial_check import pkt_check_pkg::*; (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           clr,
	input  wire           lane_flags_t beat_sop,
	input  wire           beat_data_t  beat_data,
	output lane_flags_t   bad_dest,
	output lane_flags_t   bad_serial,
	output serial_table_t exp_serial
);

	// start word of the beat, zero when no lane carries sop
	lane_word_t sop_word;
	mac_addr_t  sop_addr;
	serial_t    sop_serial;

	// expected serials with the increment of the packet in stage two applied
	serial_table_t fwd_serial;

	// stage one compare results, one bit per destination
	logic [`PKT_NUM_DEST-1:0] dst_hit;
	logic [`PKT_NUM_DEST-1:0] ser_hit;

	// stage one registers
	logic [`PKT_NUM_DEST-1:0] dst_match;
	logic [`PKT_NUM_DEST-1:0] ser_match;
	lane_flags_t              sop_r;

	// destination whose packet was correct and whose serial moves on
	logic [`PKT_NUM_DEST-1:0] ser_inc;

	// only one lane may carry sop, so OR-ing the selected lanes is a plain mux
	always_comb begin
		sop_word = '0;
		for (int i = 0; i < `PKT_WORDS; i++) begin
			if (beat_sop[i]) begin
				sop_word = sop_word | beat_data[i];
			end
		end
	end

	assign sop_addr   = sop_word[63:16];
	assign sop_serial = sop_word[15:0];

	assign ser_inc = dst_match & ser_match;

	for (genvar k = 0; k < `PKT_NUM_DEST; k++) begin : g_dest
		// a correct packet one beat ahead has not reached the table yet.
		// Looking ahead by its increment keeps back-to-back packets to one
		// destination from being flagged against a stale serial
		assign fwd_serial[k] = exp_serial[k] + serial_t'(ser_inc[k]);

		assign dst_hit[k] = (|beat_sop) && (sop_addr == dest_table[k]);
		assign ser_hit[k] = (sop_serial == fwd_serial[k]);
	end

	// stage one, register the match vectors and the sop lane
	always_ff @(posedge clk) begin
		if (!rst_n || clr) begin
			dst_match <= '0;
			ser_match <= '0;
			sop_r     <= '0;
		end else begin
			dst_match <= dst_hit;
			ser_match <= ser_hit;
			sop_r     <= beat_sop;
		end
	end

	// stage two, turn the matches into per-lane error flags
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bad_dest   <= '0;
			bad_serial <= '0;
		end else begin
			bad_dest   <= sop_r & {`PKT_WORDS{~|dst_match}};
			bad_serial <= sop_r & {`PKT_WORDS{|(dst_match & ~ser_match)}};
		end
	end

	// the table only moves for a destination whose packet carried the right serial.
	// fwd_serial already holds that increment and wraps at 16 bits
	always_ff @(posedge clk) begin
		if (!rst_n || clr) begin
			exp_serial <= '0;
		end else begin
			exp_serial <= fwd_serial;
		end
	end

	// the source may start at most one packet per beat
	one_sop_per_beat: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(beat_sop)
	)
	else $error("more than one sop in a beat, sop=%b", beat_sop);

	// the addresses in dest_table are distinct, so a start word hits one entry at most
	dest_match_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(dst_match)
	)
	else $error("start word matched several destinations, match=%b", dst_match);

endmodule

`default_nettype wire

// File: logic/err_tally.sv
// error tally with three wrapping counters that add the flagged lanes of each cycle
`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_config.svh"

module err_tally import pkt_check_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        clr,
	input  wire        lane_flags_t bad_term,
	input  wire        lane_flags_t bad_dest,
	input  wire        lane_flags_t bad_serial,
	output err_count_t term_cnt,
	output err_count_t dest_cnt,
	output err_count_t serial_cnt
);

	// counter 0 is the terminator count, 1 the destination count, 2 the serial count
	localparam int unsigned num_cnt = 3;

	lane_flags_t flags [num_cnt];
	err_count_t  cnt   [num_cnt];

	// number of lanes flagged in one cycle
	function automatic err_count_t count_set(input lane_flags_t lane_bits);
		err_count_t total;
		total = '0;
		for (int i = 0; i < `PKT_WORDS; i++) begin
			total = total + err_count_t'(lane_bits[i]);
		end
		return total;
	endfunction

	assign flags = '{bad_term, bad_dest, bad_serial};

	// several lanes can fail in the same beat, so each counter adds a lane count
	always_ff @(posedge clk) begin
		if (!rst_n || clr) begin
			for (int c = 0; c < num_cnt; c++) begin
				cnt[c] <= '0;
			end
		end else begin
			for (int c = 0; c < num_cnt; c++) begin
				cnt[c] <= cnt[c] + count_set(flags[c]);
			end
		end
	end

	assign term_cnt   = cnt[0];
	assign dest_cnt   = cnt[1];
	assign serial_cnt = cnt[2];

	for (genvar c = 0; c < num_cnt; c++) begin : g_forward
		// outside reset and clr a counter only moves forward, by at most one
		// beat's worth of lanes, the modulo difference also covers the wrap
		cnt_forward: assert property (
			@(posedge clk) disable iff (!rst_n)
			$past(rst_n) && !$past(clr) |->
				err_count_t'(cnt[c] - $past(cnt[c])) <= err_count_t'(`PKT_WORDS)
		)
		else $error("error counter %0d moved backwards or jumped", c);
	end

endmodule

`default_nettype wire

// File: logic/pkt_sanity_check.sv
// packet sanity checker top that registers the bus beat and feeds both checkers and the tally
`timescale 1ns/1ps
`default_nettype none

module pkt_sanity_check import pkt_check_pkg::*; (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           clr,
	input  wire           in_valid,
	input  wire           lane_flags_t in_sop,
	input  wire           lane_flags_t in_eop,
	input  wire           lane_flags_t in_pad,
	input  wire           beat_data_t  in_data,
	output err_count_t    term_cnt,
	output err_count_t    dest_cnt,
	output err_count_t    serial_cnt,
	output serial_table_t exp_serial
);

	// registered beat shared by both checkers
	lane_flags_t beat_sop;
	lane_flags_t beat_eop;
	lane_flags_t beat_pad;
	beat_data_t  beat_data;

	// per-lane error flags from the checkers
	lane_flags_t bad_term;
	lane_flags_t bad_dest;
	lane_flags_t bad_serial;

	// an idle beat becomes a beat with all flags low, whatever the bus carries
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat_sop <= '0;
			beat_eop <= '0;
			beat_pad <= '0;
		end else begin
			beat_sop <= in_valid ? in_sop : '0;
			beat_eop <= in_valid ? in_eop : '0;
			beat_pad <= in_valid ? in_pad : '0;
		end
	end

	// data is only looked at where a flag is set
	always_ff @(posedge clk) begin
		beat_data <= in_data;
	end

	term_check u_term_check (
		.clk       (clk),
		.rst_n     (rst_n),
		.beat_eop  (beat_eop),
		.beat_pad  (beat_pad),
		.beat_data (beat_data),
		.bad_term  (bad_term)
	);

	dest_serial_check u_dest_serial_check (
		.clk        (clk),
		.rst_n      (rst_n),
		.clr        (clr),
		.beat_sop   (beat_sop),
		.beat_data  (beat_data),
		.bad_dest   (bad_dest),
		.bad_serial (bad_serial),
		.exp_serial (exp_serial)
	);

	err_tally u_err_tally (
		.clk        (clk),
		.rst_n      (rst_n),
		.clr        (clr),
		.bad_term   (bad_term),
		.bad_dest   (bad_dest),
		.bad_serial (bad_serial),
		.term_cnt   (term_cnt),
		.dest_cnt   (dest_cnt),
		.serial_cnt (serial_cnt)
	);

endmodule

`default_nettype wire

// File: verif/tb_pkt_sanity_check.sv
// directed testbench for the packet sanity checker with a packet-building model and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "pkt_check_config.svh"

module tb_pkt_sanity_check import pkt_check_pkg::*; ();

	// budget of the whole run, used by the watchdog
	localparam int max_packets       = 45;
	localparam int beats_per_packet  = 16;
	localparam int idle_beats        = 80;
	localparam int total_beats       = max_packets * beats_per_packet + idle_beats;
	localparam real watchdog_ns      = total_beats * 4.0 * 1.5;

	logic          clk;
	logic          rst_n;
	logic          clr;
	logic          in_valid;
	lane_flags_t   in_sop;
	lane_flags_t   in_eop;
	lane_flags_t   in_pad;
	beat_data_t    in_data;
	err_count_t    term_cnt;
	err_count_t    dest_cnt;
	err_count_t    serial_cnt;
	serial_table_t exp_serial;

	// expected state of the checker
	err_count_t    model_term;
	err_count_t    model_dest;
	err_count_t    model_serial_cnt;
	serial_table_t model_serial;

	// beat under construction
	lane_flags_t   cur_sop;
	lane_flags_t   cur_eop;
	lane_flags_t   cur_pad;
	beat_data_t    cur_data;
	int            lane_pos;
	logic          gaps_on;

	pkt_sanity_check uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.clr        (clr),
		.in_valid   (in_valid),
		.in_sop     (in_sop),
		.in_eop     (in_eop),
		.in_pad     (in_pad),
		.in_data    (in_data),
		.term_cnt   (term_cnt),
		.dest_cnt   (dest_cnt),
		.serial_cnt (serial_cnt),
		.exp_serial (exp_serial)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	initial begin
		#(watchdog_ns);
		abort_run($sformatf("watchdog expired after %0t ns, the tests did not finish", $time));
	end

	function automatic lane_word_t random_word();
		return lane_word_t'({$urandom, $urandom});
	endfunction

	// index of a known destination, or -1 for an address outside the table
	function automatic int find_dest(input mac_addr_t addr);
		for (int k = 0; k < `PKT_NUM_DEST; k++) begin
			if (dest_table[k] == addr) begin
				return k;
			end
		end
		return -1;
	endfunction

	task automatic drive_beat(input logic valid, input lane_flags_t sop, input lane_flags_t eop,
		input lane_flags_t pad, input beat_data_t data);
		@(posedge clk);
		#1;
		in_valid = valid;
		in_sop   = sop;
		in_eop   = eop;
		in_pad   = pad;
		in_data  = data;
	endtask

	// idle beats carry random flags when gaps are on, the DUT must ignore them
	task automatic drive_idle(input int n);
		beat_data_t junk;
		for (int i = 0; i < n; i++) begin
			for (int l = 0; l < `PKT_WORDS; l++) begin
				junk[l] = random_word();
			end
			if (gaps_on) begin
				drive_beat(1'b0, lane_flags_t'($urandom), lane_flags_t'($urandom),
					lane_flags_t'($urandom), junk);
			end else begin
				drive_beat(1'b0, '0, '0, '0, junk);
			end
		end
	endtask

	// send the collected lanes as one valid beat, unused lanes carry no flags
	task automatic flush_beat;
		if (lane_pos == 0) begin
			return;
		end
		for (int l = lane_pos; l < `PKT_WORDS; l++) begin
			cur_data[l] = random_word();
		end
		drive_beat(1'b1, cur_sop, cur_eop, cur_pad, cur_data);
		if (gaps_on) begin
			drive_idle($urandom_range(0, 3));
		end
		cur_sop  = '0;
		cur_eop  = '0;
		cur_pad  = '0;
		lane_pos = 0;
	endtask

	task automatic put_word(input lane_word_t word, input logic sop, input logic eop,
		input logic pad);
		// a second start in the same beat goes to the next beat
		if (sop && cur_sop != '0) begin
			flush_beat();
		end
		cur_data[lane_pos] = word;
		cur_sop[lane_pos]  = sop;
		cur_eop[lane_pos]  = eop;
		cur_pad[lane_pos]  = pad;
		lane_pos++;
		if (lane_pos == `PKT_WORDS) begin
			flush_beat();
		end
	endtask

	// build one packet and apply the checker rules to the model
	task automatic send_packet(input mac_addr_t addr, input serial_t ser, input int n_body,
		input lane_word_t last, input logic pad);
		int idx;
		idx = find_dest(addr);
		if (idx < 0) begin
			model_dest++;
		end else if (ser == model_serial[idx]) begin
			model_serial[idx]++;
		end else begin
			model_serial_cnt++;
		end
		if (!pad && last != term_word) begin
			model_term++;
		end
		put_word({addr, ser}, 1'b1, 1'b0, 1'b0);
		for (int i = 0; i < n_body; i++) begin
			put_word(random_word(), 1'b0, 1'b0, 1'b0);
		end
		put_word(last, 1'b0, 1'b1, pad);
	endtask

	task automatic check_count(input string name, input err_count_t expected,
		input err_count_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail at %0t ns: %s expected %0d, actual %0d",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_serial_table(input serial_table_t expected, input serial_table_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("Fail at %0t ns: exp_serial expected %h, actual %h",
				$time, expected, actual));
		end
	endtask

	task automatic check_flags_idle;
		if (uut.bad_term !== '0) begin
			abort_run($sformatf("Fail at %0t ns: bad_term expected %b, actual %b",
				$time, lane_flags_t'(0), uut.bad_term));
		end
		if (uut.bad_dest !== '0) begin
			abort_run($sformatf("Fail at %0t ns: bad_dest expected %b, actual %b",
				$time, lane_flags_t'(0), uut.bad_dest));
		end
		if (uut.bad_serial !== '0) begin
			abort_run($sformatf("Fail at %0t ns: bad_serial expected %b, actual %b",
				$time, lane_flags_t'(0), uut.bad_serial));
		end
	endtask

	// let the pipeline drain, then compare everything against the model
	task automatic finish_test;
		flush_beat();
		drive_idle(6);
		check_count("term_cnt", model_term, term_cnt);
		check_count("dest_cnt", model_dest, dest_cnt);
		check_count("serial_cnt", model_serial_cnt, serial_cnt);
		check_serial_table(model_serial, exp_serial);
		check_flags_idle();
	endtask

	task automatic test_good_traffic;
		for (int rep = 0; rep < 3; rep++) begin
			for (int k = 0; k < `PKT_NUM_DEST; k++) begin
				send_packet(dest_table[k], model_serial[k], $urandom_range(0, 3), term_word, 1'b0);
			end
		end
		// two one-beat packets in adjacent beats to the same destination
		// the second start is compared before the table holds the first increment
		flush_beat();
		send_packet(dest_table[1], model_serial[1], 0, term_word, 1'b0);
		send_packet(dest_table[1], model_serial[1], 0, term_word, 1'b0);
		finish_test();
	endtask

	task automatic test_term_errors;
		lane_word_t bad_word;
		for (int b = 0; b < `PKT_WIDTH / 8; b++) begin
			bad_word = term_word ^ (lane_word_t'(1) << (8 * b + $urandom_range(0, 7)));
			send_packet(dest_table[b % `PKT_NUM_DEST], model_serial[b % `PKT_NUM_DEST],
				$urandom_range(0, 2), bad_word, 1'b0);
		end
		// a padded end word is never compared
		send_packet(dest_table[0], model_serial[0], 1, random_word(), 1'b1);
		send_packet(dest_table[3], model_serial[3], 2, term_word ^ 64'h1, 1'b1);
		finish_test();
	endtask

	task automatic test_unknown_dest;
		send_packet(48'h0, serial_t'($urandom), 1, term_word, 1'b0);
		send_packet(dest_table[1] ^ 48'h0100, model_serial[1], 0, term_word, 1'b0);
		send_packet(48'hfeed_0000_0001, serial_t'($urandom), 2, term_word, 1'b0);
		finish_test();
	endtask

	task automatic test_serial_errors;
		send_packet(dest_table[2], model_serial[2], 1, term_word, 1'b0);
		send_packet(dest_table[2], serial_t'(model_serial[2] + 16'd2), 1, term_word, 1'b0);
		send_packet(dest_table[2], serial_t'(model_serial[2] - 16'd1), 0, term_word, 1'b0);
		send_packet(dest_table[2], model_serial[2], 2, term_word, 1'b0);
		send_packet(dest_table[3], serial_t'(model_serial[3] + 16'd5), 1, term_word, 1'b0);
		finish_test();
	endtask

	task automatic test_gaps;
		gaps_on = 1'b1;
		drive_idle(2);
		for (int i = 0; i < 6; i++) begin
			send_packet(dest_table[i % `PKT_NUM_DEST], model_serial[i % `PKT_NUM_DEST],
				$urandom_range(0, 3), term_word, 1'b0);
		end
		flush_beat();
		gaps_on = 1'b0;
		finish_test();
	endtask

	task automatic test_clear;
		@(posedge clk);
		#1;
		clr = 1'b1;
		@(posedge clk);
		#1;
		clr = 1'b0;
		model_term       = '0;
		model_dest       = '0;
		model_serial_cnt = '0;
		model_serial     = '0;
		finish_test();
		for (int k = 0; k < `PKT_NUM_DEST; k++) begin
			send_packet(dest_table[k], 16'd0, 1, term_word, 1'b0);
		end
		finish_test();
	endtask

	initial begin
		void'($urandom(21));
		rst_n            = 1'b0;
		clr              = 1'b0;
		in_valid         = 1'b0;
		in_sop           = '0;
		in_eop           = '0;
		in_pad           = '0;
		in_data          = '0;
		model_term       = '0;
		model_dest       = '0;
		model_serial_cnt = '0;
		model_serial     = '0;
		cur_sop          = '0;
		cur_eop          = '0;
		cur_pad          = '0;
		cur_data         = '0;
		lane_pos         = 0;
		gaps_on          = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		finish_test();
		test_good_traffic();
		test_term_errors();
		test_unknown_dest();
		test_serial_errors();
		test_gaps();
		test_clear();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
logic/pkt_check_pkg.sv
logic/term_check.sv
logic/dest_serial_check.sv
logic/err_tally.sv
logic/pkt_sanity_check.sv
verif/tb_pkt_sanity_check.sv
